// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module decode_stage_tb -f verilog.f -o decode_sim
output=$(./obj_dir/decode_sim)
echo "$output"

if grep -qx "Everything OK" <<< "$output"; then
  exit 0
else
  exit 1
fi

// File: sim/decode_stage_chk.sv
`timescale 1ns/10ps

module decode_stage_chk (
  input logic                clk,
  input logic                reset_i,
  input logic                in_ready_o,
  input logic                out_valid_o,
  input logic                out_ready_i,
  input codes_pkg::decoded_t out_rec_o
);

  valid_low_after_reset: assert property (@(posedge clk) reset_i |=> !out_valid_o)
    else $error("out_valid_o high in the cycle after reset");

  // A stalled record must wait unchanged.
  record_held_on_stall: assert property (@(posedge clk) disable iff (reset_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_rec_o))
    else $error("Stalled output record dropped or changed");

  ready_when_empty: assert property (@(posedge clk) disable iff (reset_i)
    !out_valid_o |-> in_ready_o)
    else $error("in_ready_o low while the stage is empty");

endmodule

bind decode_stage decode_stage_chk u_chk (
  .clk         (clk),
  .reset_i     (reset_i),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .out_rec_o   (out_rec_o)
);

// File: sim/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb;

  localparam int NUM_VEC    = 38;
  localparam int STIM_WORDS = NUM_VEC * 5; // Word, op, dest, write flag, immediate.
  localparam int MAX_IDLE   = 40;

  logic                clk;
  logic                reset_i;
  logic                in_valid_i;
  codes_pkg::word_t    in_word_i;
  logic                in_ready_o;
  logic                out_valid_o;
  codes_pkg::decoded_t out_rec_o;
  logic                out_ready_i;

  logic [31:0] stim_mem [0:STIM_WORDS-1];
  int          checks;
  int          errors;
  bit          timed_out;

  decode_stage DUT (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_word_i   (in_word_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_rec_o   (out_rec_o),
    .out_ready_i (out_ready_i)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] stim_at(input int vec, input int col);
    logic [7:0] idx;
    idx = 8'(vec * 5 + col);
    return stim_mem[idx];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Raw fields are plain slices of the word, the rest comes from the file.
  task automatic check_record(input int vec);
    logic [31:0] word;
    word = stim_at(vec, 0);
    check_value($sformatf("vec%0d full_op", vec), stim_at(vec, 1), 32'(out_rec_o.full_op));
    check_value($sformatf("vec%0d dest", vec), stim_at(vec, 2), 32'(out_rec_o.dest));
    check_value($sformatf("vec%0d writes_reg", vec), stim_at(vec, 3),
                32'(out_rec_o.writes_reg));
    check_value($sformatf("vec%0d imm32", vec), stim_at(vec, 4), out_rec_o.imm32);
    check_value($sformatf("vec%0d rs", vec), 32'(word[25:21]), 32'(out_rec_o.rs));
    check_value($sformatf("vec%0d rt", vec), 32'(word[20:16]), 32'(out_rec_o.rt));
    check_value($sformatf("vec%0d shamt", vec), 32'(word[10:6]), 32'(out_rec_o.shamt));
    check_value($sformatf("vec%0d target", vec), 32'(word[25:0]), 32'(out_rec_o.target));
  endtask

  // Sends every vector and collects every record. Handshakes are sampled
  // one step after the falling edge, where they hold until the rising edge.
  task automatic run_stream(input bit stalls);
    int acc_q[$];
    int sent;
    int got;
    int idle;
    int cycle;
    int acc_cycle;
    bit holding;
    bit in_fire;
    bit out_fire;
    sent    = 0;
    got     = 0;
    idle    = 0;
    cycle   = 0;
    holding = 1'b0;
    while (got < NUM_VEC && !timed_out) begin
      @(negedge clk);
      cycle++;
      if (!holding) begin
        if (sent < NUM_VEC && (!stalls || $urandom_range(0, 3) != 0)) begin
          in_valid_i = 1'b1;
          in_word_i  = stim_at(sent, 0);
        end else begin
          in_valid_i = 1'b0;
        end
      end
      out_ready_i = !stalls || ($urandom_range(0, 2) != 0);
      #1;
      in_fire  = in_valid_i && in_ready_o;
      out_fire = out_valid_o && out_ready_i;
      holding  = in_valid_i && !in_fire; // Word stays on the bus until taken.
      if (!stalls && sent < NUM_VEC) begin
        check_value("stream accept", 1, 32'(in_fire));
      end
      if (in_fire) begin
        acc_q.push_back(cycle);
        sent++;
      end
      if (out_fire) begin
        if (acc_q.size() == 0) begin
          errors++;
          $display("Record delivered although no word was accepted for it");
        end else begin
          acc_cycle = acc_q.pop_front();
          if (!stalls) begin
            check_value($sformatf("vec%0d latency", got), 32'(acc_cycle + 1), 32'(cycle));
          end
        end
        check_record(got);
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle > MAX_IDLE) begin
          errors++;
          timed_out = 1'b1;
          $display("Timeout: no record delivered for %0d cycles", MAX_IDLE);
        end
      end
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset_i     = 1'b1;
    in_valid_i  = 1'b0;
    in_word_i   = '0;
    out_ready_i = 1'b0;
    checks      = 0;
    errors      = 0;
    timed_out   = 1'b0;
    void'($urandom(32'he7ba9baa));
    $readmemh("sim/decode_stim.txt", stim_mem);
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    #1;
    check_value("reset out_valid", 0, 32'(out_valid_o));
    check_value("reset in_ready", 1, 32'(in_ready_o));
    run_stream(1'b1); // Random gaps and back-pressure.
    if (!timed_out) begin
      run_stream(1'b0);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: sim/decode_stim.txt
// Columns in hex: instruction word, full_op, dest, writes_reg, imm32.
// One instruction per line, checked in file order.
2109ffff 06 09 1 ffffffff
24021234 07 02 1 00001234
28858000 08 05 1 ffff8000
2c667fff 09 06 1 00007fff
302aff00 0a 0a 1 0000ff00
344b8001 0b 0b 1 00008001
398d00ff 0c 0d 1 000000ff
3c088765 0d 08 1 87650000
30a08000 0a 00 0 00008000 // ANDI into r0.
8fbffffc 11 1f 1 fffffffc
80820010 0e 02 1 00000010
94a38002 13 03 1 ffff8002
afbf0004 18 00 0 00000004
a022ff80 15 00 0 ffffff80
1022fffe 02 00 0 fffffffe
14600003 03 00 0 00000003
08100040 00 00 0 00000040
0fffffff 01 1f 1 ffffffff // JAL links to r31.
00221820 2c 03 1 00001820
00850023 2f 00 0 00000023
00c7f827 33 1f 1 fffff827
00094100 1a 08 1 00004100
016c5007 1f 0a 1 00005007
03e00008 20 00 0 00000008
0080f809 21 1f 1 fffff809
00008010 24 10 1 ffff8010
00850018 28 00 0 00000018
0000000c 22 00 0 0000000c
04400010 36 00 0 00000010
04718000 39 1f 1 ffff8000
04100004 38 1f 1 00000004
fc00ffff 3f 00 0 ffffffff
40801000 3f 00 0 00001000 // Unlisted primary opcode.
00222801 3f 00 0 00002801
04228000 3f 00 0 ffff8000 // Unlisted REGIMM rt code.
0000003f 3f 00 0 0000003f
04a1fff0 37 00 0 fffffff0
00000012 26 00 0 00000012

// File: source/codes_pkg.sv
package codes_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regaddr_t;
  typedef logic [15:0] imm16_t;
  typedef logic [4:0]  shamt_t;
  typedef logic [25:0] target_t;

  localparam regaddr_t ZERO_REG = 5'd0;
  localparam regaddr_t LINK_REG = 5'd31; // Return address for the linking jumps.

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
    OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
    OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
    OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
    OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LWL   = 6'h22, OP_LW    = 6'h23,
    OP_LBU     = 6'h24, OP_LHU    = 6'h25, OP_LWR   = 6'h26, OP_SB    = 6'h28,
    OP_SH      = 6'h29, OP_SWL    = 6'h2a, OP_SW    = 6'h2b, OP_SWR   = 6'h2e,
    OP_INVALID = 6'h3f
  } opcode_t;

  typedef enum logic [5:0] {
    FUNC_SLL     = 6'h00, FUNC_SRL   = 6'h02, FUNC_SRA   = 6'h03, FUNC_SLLV  = 6'h04,
    FUNC_SRLV    = 6'h06, FUNC_SRAV  = 6'h07, FUNC_JR    = 6'h08, FUNC_JALR  = 6'h09,
    FUNC_SYSCALL = 6'h0c, FUNC_BREAK = 6'h0d, FUNC_MFHI  = 6'h10, FUNC_MTHI  = 6'h11,
    FUNC_MFLO    = 6'h12, FUNC_MTLO  = 6'h13, FUNC_MULT  = 6'h18, FUNC_MULTU = 6'h19,
    FUNC_DIV     = 6'h1a, FUNC_DIVU  = 6'h1b, FUNC_ADD   = 6'h20, FUNC_ADDU  = 6'h21,
    FUNC_SUB     = 6'h22, FUNC_SUBU  = 6'h23, FUNC_AND   = 6'h24, FUNC_OR    = 6'h25,
    FUNC_XOR     = 6'h26, FUNC_NOR   = 6'h27, FUNC_SLT   = 6'h2a, FUNC_SLTU  = 6'h2b,
    FUNC_INVALID = 6'h3f
  } func_t;

  typedef enum logic [4:0] {
    REGIMM_BLTZ    = 5'h00,
    REGIMM_BGEZ    = 5'h01,
    REGIMM_BLTZAL  = 5'h10,
    REGIMM_BGEZAL  = 5'h11,
    REGIMM_INVALID = 5'h1f
  } regimm_t;

  // Numbering is shared with the stimulus file.
  typedef enum logic [5:0] {
    FOP_J       = 6'h00, FOP_JAL     = 6'h01, FOP_BEQ     = 6'h02, FOP_BNE     = 6'h03,
    FOP_BLEZ    = 6'h04, FOP_BGTZ    = 6'h05, FOP_ADDI    = 6'h06, FOP_ADDIU   = 6'h07,
    FOP_SLTI    = 6'h08, FOP_SLTIU   = 6'h09, FOP_ANDI    = 6'h0a, FOP_ORI     = 6'h0b,
    FOP_XORI    = 6'h0c, FOP_LUI     = 6'h0d, FOP_LB      = 6'h0e, FOP_LH      = 6'h0f,
    FOP_LWL     = 6'h10, FOP_LW      = 6'h11, FOP_LBU     = 6'h12, FOP_LHU     = 6'h13,
    FOP_LWR     = 6'h14, FOP_SB      = 6'h15, FOP_SH      = 6'h16, FOP_SWL     = 6'h17,
    FOP_SW      = 6'h18, FOP_SWR     = 6'h19, FOP_SLL     = 6'h1a, FOP_SRL     = 6'h1b,
    FOP_SRA     = 6'h1c, FOP_SLLV    = 6'h1d, FOP_SRLV    = 6'h1e, FOP_SRAV    = 6'h1f,
    FOP_JR      = 6'h20, FOP_JALR    = 6'h21, FOP_SYSCALL = 6'h22, FOP_BREAK   = 6'h23,
    FOP_MFHI    = 6'h24, FOP_MTHI    = 6'h25, FOP_MFLO    = 6'h26, FOP_MTLO    = 6'h27,
    FOP_MULT    = 6'h28, FOP_MULTU   = 6'h29, FOP_DIV     = 6'h2a, FOP_DIVU    = 6'h2b,
    FOP_ADD     = 6'h2c, FOP_ADDU    = 6'h2d, FOP_SUB     = 6'h2e, FOP_SUBU    = 6'h2f,
    FOP_AND     = 6'h30, FOP_OR      = 6'h31, FOP_XOR     = 6'h32, FOP_NOR     = 6'h33,
    FOP_SLT     = 6'h34, FOP_SLTU    = 6'h35, FOP_BLTZ    = 6'h36, FOP_BGEZ    = 6'h37,
    FOP_BLTZAL  = 6'h38, FOP_BGEZAL  = 6'h39,
    FOP_INVALID = 6'h3f
  } full_op_t;

  // Fields as sliced from the word, before any selection or extension.
  typedef struct packed {
    full_op_t full_op;
    regaddr_t rs;
    regaddr_t rt;
    regaddr_t rd;
    imm16_t   imm16;
    shamt_t   shamt;
    target_t  target;
  } raw_fields_t;

  typedef struct packed {
    full_op_t full_op;
    regaddr_t rs;
    regaddr_t rt;
    regaddr_t dest;
    logic     writes_reg; // Low when dest is the zero register.
    word_t    imm32;
    shamt_t   shamt;
    target_t  target;
  } decoded_t;

endpackage

// File: source/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                in_valid_i,
  input  codes_pkg::word_t    in_word_i,
  output logic                in_ready_o,
  output logic                out_valid_o,
  output codes_pkg::decoded_t out_rec_o,
  input  logic                out_ready_i
);

  codes_pkg::word_t       held_word;
  codes_pkg::raw_fields_t fields;

  // The only register in the stage. Decode after it is combinational.
  instr_hold u_hold (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_word_i   (in_word_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_word_o  (held_word),
    .out_ready_i (out_ready_i)
  );

  op_decode u_decode (
    .word_i   (held_word),
    .fields_o (fields)
  );

  operand_select u_select (
    .fields_i (fields),
    .rec_o    (out_rec_o)
  );

endmodule

// File: source/instr_hold.sv
`timescale 1ns/10ps

module instr_hold (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              in_valid_i,
  input  codes_pkg::word_t  in_word_i,
  output logic              in_ready_o,
  output logic              out_valid_o,
  output codes_pkg::word_t  out_word_o,
  input  logic              out_ready_i
);

  logic             full;
  codes_pkg::word_t ihold;
  logic             accept;

  // Take a new word when empty or when the held one leaves this cycle.
  assign in_ready_o = !full || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      full <= 1'b0;
    end else if (in_ready_o) begin
      full <= in_valid_i; // Refill or drain.
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ihold <= in_word_i;
    end
  end

  assign out_valid_o = full;
  assign out_word_o  = ihold;

endmodule

// File: source/op_decode.sv
`timescale 1ns/10ps

module op_decode (
  input  codes_pkg::word_t       word_i,
  output codes_pkg::raw_fields_t fields_o
);

  codes_pkg::opcode_t  opcode;
  codes_pkg::func_t    func;
  codes_pkg::regimm_t  regimm;
  codes_pkg::full_op_t full_op;

  function automatic codes_pkg::opcode_t to_opcode(logic [5:0] raw);
    case (raw)
      codes_pkg::OP_SPECIAL, codes_pkg::OP_REGIMM, codes_pkg::OP_J, codes_pkg::OP_JAL,
      codes_pkg::OP_BEQ, codes_pkg::OP_BNE, codes_pkg::OP_BLEZ, codes_pkg::OP_BGTZ,
      codes_pkg::OP_ADDI, codes_pkg::OP_ADDIU, codes_pkg::OP_SLTI, codes_pkg::OP_SLTIU,
      codes_pkg::OP_ANDI, codes_pkg::OP_ORI, codes_pkg::OP_XORI, codes_pkg::OP_LUI,
      codes_pkg::OP_LB, codes_pkg::OP_LH, codes_pkg::OP_LWL, codes_pkg::OP_LW,
      codes_pkg::OP_LBU, codes_pkg::OP_LHU, codes_pkg::OP_LWR, codes_pkg::OP_SB,
      codes_pkg::OP_SH, codes_pkg::OP_SWL, codes_pkg::OP_SW, codes_pkg::OP_SWR:
        to_opcode = codes_pkg::opcode_t'(raw);
      default:
        to_opcode = codes_pkg::OP_INVALID;
    endcase
  endfunction

  function automatic codes_pkg::func_t to_func(logic [5:0] raw);
    case (raw)
      codes_pkg::FUNC_SLL, codes_pkg::FUNC_SRL, codes_pkg::FUNC_SRA, codes_pkg::FUNC_SLLV,
      codes_pkg::FUNC_SRLV, codes_pkg::FUNC_SRAV, codes_pkg::FUNC_JR, codes_pkg::FUNC_JALR,
      codes_pkg::FUNC_SYSCALL, codes_pkg::FUNC_BREAK, codes_pkg::FUNC_MFHI,
      codes_pkg::FUNC_MTHI, codes_pkg::FUNC_MFLO, codes_pkg::FUNC_MTLO,
      codes_pkg::FUNC_MULT, codes_pkg::FUNC_MULTU, codes_pkg::FUNC_DIV, codes_pkg::FUNC_DIVU,
      codes_pkg::FUNC_ADD, codes_pkg::FUNC_ADDU, codes_pkg::FUNC_SUB, codes_pkg::FUNC_SUBU,
      codes_pkg::FUNC_AND, codes_pkg::FUNC_OR, codes_pkg::FUNC_XOR, codes_pkg::FUNC_NOR,
      codes_pkg::FUNC_SLT, codes_pkg::FUNC_SLTU:
        to_func = codes_pkg::func_t'(raw);
      default:
        to_func = codes_pkg::FUNC_INVALID;
    endcase
  endfunction

  function automatic codes_pkg::regimm_t to_regimm(logic [4:0] raw);
    case (raw)
      codes_pkg::REGIMM_BLTZ, codes_pkg::REGIMM_BGEZ,
      codes_pkg::REGIMM_BLTZAL, codes_pkg::REGIMM_BGEZAL:
        to_regimm = codes_pkg::regimm_t'(raw);
      default:
        to_regimm = codes_pkg::REGIMM_INVALID;
    endcase
  endfunction

  assign opcode = to_opcode(word_i[31:26]);
  assign func   = to_func(word_i[5:0]);
  assign regimm = to_regimm(word_i[20:16]); // REGIMM selects on the rt field.

  always_comb begin
    full_op = codes_pkg::FOP_INVALID;
    case (opcode)
      codes_pkg::OP_J:     full_op = codes_pkg::FOP_J;
      codes_pkg::OP_JAL:   full_op = codes_pkg::FOP_JAL;
      codes_pkg::OP_BEQ:   full_op = codes_pkg::FOP_BEQ;
      codes_pkg::OP_BNE:   full_op = codes_pkg::FOP_BNE;
      codes_pkg::OP_BLEZ:  full_op = codes_pkg::FOP_BLEZ;
      codes_pkg::OP_BGTZ:  full_op = codes_pkg::FOP_BGTZ;
      codes_pkg::OP_ADDI:  full_op = codes_pkg::FOP_ADDI;
      codes_pkg::OP_ADDIU: full_op = codes_pkg::FOP_ADDIU;
      codes_pkg::OP_SLTI:  full_op = codes_pkg::FOP_SLTI;
      codes_pkg::OP_SLTIU: full_op = codes_pkg::FOP_SLTIU;
      codes_pkg::OP_ANDI:  full_op = codes_pkg::FOP_ANDI;
      codes_pkg::OP_ORI:   full_op = codes_pkg::FOP_ORI;
      codes_pkg::OP_XORI:  full_op = codes_pkg::FOP_XORI;
      codes_pkg::OP_LUI:   full_op = codes_pkg::FOP_LUI;
      codes_pkg::OP_LB:    full_op = codes_pkg::FOP_LB;
      codes_pkg::OP_LH:    full_op = codes_pkg::FOP_LH;
      codes_pkg::OP_LWL:   full_op = codes_pkg::FOP_LWL;
      codes_pkg::OP_LW:    full_op = codes_pkg::FOP_LW;
      codes_pkg::OP_LBU:   full_op = codes_pkg::FOP_LBU;
      codes_pkg::OP_LHU:   full_op = codes_pkg::FOP_LHU;
      codes_pkg::OP_LWR:   full_op = codes_pkg::FOP_LWR;
      codes_pkg::OP_SB:    full_op = codes_pkg::FOP_SB;
      codes_pkg::OP_SH:    full_op = codes_pkg::FOP_SH;
      codes_pkg::OP_SWL:   full_op = codes_pkg::FOP_SWL;
      codes_pkg::OP_SW:    full_op = codes_pkg::FOP_SW;
      codes_pkg::OP_SWR:   full_op = codes_pkg::FOP_SWR;
      codes_pkg::OP_SPECIAL: begin
        case (func)
          codes_pkg::FUNC_SLL:     full_op = codes_pkg::FOP_SLL;
          codes_pkg::FUNC_SRL:     full_op = codes_pkg::FOP_SRL;
          codes_pkg::FUNC_SRA:     full_op = codes_pkg::FOP_SRA;
          codes_pkg::FUNC_SLLV:    full_op = codes_pkg::FOP_SLLV;
          codes_pkg::FUNC_SRLV:    full_op = codes_pkg::FOP_SRLV;
          codes_pkg::FUNC_SRAV:    full_op = codes_pkg::FOP_SRAV;
          codes_pkg::FUNC_JR:      full_op = codes_pkg::FOP_JR;
          codes_pkg::FUNC_JALR:    full_op = codes_pkg::FOP_JALR;
          codes_pkg::FUNC_SYSCALL: full_op = codes_pkg::FOP_SYSCALL;
          codes_pkg::FUNC_BREAK:   full_op = codes_pkg::FOP_BREAK;
          codes_pkg::FUNC_MFHI:    full_op = codes_pkg::FOP_MFHI;
          codes_pkg::FUNC_MTHI:    full_op = codes_pkg::FOP_MTHI;
          codes_pkg::FUNC_MFLO:    full_op = codes_pkg::FOP_MFLO;
          codes_pkg::FUNC_MTLO:    full_op = codes_pkg::FOP_MTLO;
          codes_pkg::FUNC_MULT:    full_op = codes_pkg::FOP_MULT;
          codes_pkg::FUNC_MULTU:   full_op = codes_pkg::FOP_MULTU;
          codes_pkg::FUNC_DIV:     full_op = codes_pkg::FOP_DIV;
          codes_pkg::FUNC_DIVU:    full_op = codes_pkg::FOP_DIVU;
          codes_pkg::FUNC_ADD:     full_op = codes_pkg::FOP_ADD;
          codes_pkg::FUNC_ADDU:    full_op = codes_pkg::FOP_ADDU;
          codes_pkg::FUNC_SUB:     full_op = codes_pkg::FOP_SUB;
          codes_pkg::FUNC_SUBU:    full_op = codes_pkg::FOP_SUBU;
          codes_pkg::FUNC_AND:     full_op = codes_pkg::FOP_AND;
          codes_pkg::FUNC_OR:      full_op = codes_pkg::FOP_OR;
          codes_pkg::FUNC_XOR:     full_op = codes_pkg::FOP_XOR;
          codes_pkg::FUNC_NOR:     full_op = codes_pkg::FOP_NOR;
          codes_pkg::FUNC_SLT:     full_op = codes_pkg::FOP_SLT;
          codes_pkg::FUNC_SLTU:    full_op = codes_pkg::FOP_SLTU;
          default:                 full_op = codes_pkg::FOP_INVALID;
        endcase
      end
      codes_pkg::OP_REGIMM: begin
        case (regimm)
          codes_pkg::REGIMM_BLTZ:   full_op = codes_pkg::FOP_BLTZ;
          codes_pkg::REGIMM_BGEZ:   full_op = codes_pkg::FOP_BGEZ;
          codes_pkg::REGIMM_BLTZAL: full_op = codes_pkg::FOP_BLTZAL;
          codes_pkg::REGIMM_BGEZAL: full_op = codes_pkg::FOP_BGEZAL;
          default:                  full_op = codes_pkg::FOP_INVALID;
        endcase
      end
      default: full_op = codes_pkg::FOP_INVALID;
    endcase
  end

  assign fields_o.full_op = full_op;
  assign fields_o.rs      = word_i[25:21];
  assign fields_o.rt      = word_i[20:16];
  assign fields_o.rd      = word_i[15:11];
  assign fields_o.imm16   = word_i[15:0];
  assign fields_o.shamt   = word_i[10:6];
  assign fields_o.target  = word_i[25:0];

endmodule

// File: source/operand_select.sv
`timescale 1ns/10ps

module operand_select (
  input  codes_pkg::raw_fields_t fields_i,
  output codes_pkg::decoded_t    rec_o
);

  codes_pkg::regaddr_t dest;
  codes_pkg::word_t    imm32;

  always_comb begin
    dest = codes_pkg::ZERO_REG; // Stores, branches and invalid write nothing.
    case (fields_i.full_op)
      codes_pkg::FOP_ADD, codes_pkg::FOP_ADDU, codes_pkg::FOP_SUB, codes_pkg::FOP_SUBU,
      codes_pkg::FOP_AND, codes_pkg::FOP_OR, codes_pkg::FOP_XOR, codes_pkg::FOP_NOR,
      codes_pkg::FOP_SLT, codes_pkg::FOP_SLTU,
      codes_pkg::FOP_SLL, codes_pkg::FOP_SRL, codes_pkg::FOP_SRA,
      codes_pkg::FOP_SLLV, codes_pkg::FOP_SRLV, codes_pkg::FOP_SRAV,
      codes_pkg::FOP_MFHI, codes_pkg::FOP_MFLO, codes_pkg::FOP_JALR:
        dest = fields_i.rd;
      codes_pkg::FOP_ADDI, codes_pkg::FOP_ADDIU, codes_pkg::FOP_SLTI, codes_pkg::FOP_SLTIU,
      codes_pkg::FOP_ANDI, codes_pkg::FOP_ORI, codes_pkg::FOP_XORI, codes_pkg::FOP_LUI,
      codes_pkg::FOP_LB, codes_pkg::FOP_LH, codes_pkg::FOP_LWL, codes_pkg::FOP_LW,
      codes_pkg::FOP_LBU, codes_pkg::FOP_LHU, codes_pkg::FOP_LWR:
        dest = fields_i.rt;
      codes_pkg::FOP_JAL, codes_pkg::FOP_BLTZAL, codes_pkg::FOP_BGEZAL:
        dest = codes_pkg::LINK_REG;
      default:
        dest = codes_pkg::ZERO_REG;
    endcase
  end

  always_comb begin
    case (fields_i.full_op)
      codes_pkg::FOP_ANDI, codes_pkg::FOP_ORI, codes_pkg::FOP_XORI:
        imm32 = {16'h0000, fields_i.imm16}; // Logic ops zero-extend.
      codes_pkg::FOP_LUI:
        imm32 = {fields_i.imm16, 16'h0000};
      default:
        imm32 = {{16{fields_i.imm16[15]}}, fields_i.imm16};
    endcase
  end

  assign rec_o.full_op    = fields_i.full_op;
  assign rec_o.rs         = fields_i.rs;
  assign rec_o.rt         = fields_i.rt;
  assign rec_o.dest       = dest;
  assign rec_o.writes_reg = (dest != codes_pkg::ZERO_REG); // r0 is never written.
  assign rec_o.imm32      = imm32;
  assign rec_o.shamt      = fields_i.shamt;
  assign rec_o.target     = fields_i.target;

endmodule

// File: verilog.f
source/codes_pkg.sv
source/instr_hold.sv
source/op_decode.sv
source/operand_select.sv
source/decode_stage.sv
sim/decode_stage_chk.sv
sim/decode_stage_tb.sv
